// File: hw/execute_memory.sv
// ALU, EX/MEM register, data memory, MEM/WB register with write-back select, hazard tags
`timescale 1ns/10ps

module execute_memory (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              ex_valid,
    input  isa_pkg::opcode_e                  ex_op,
    input  logic [isa_pkg::REG_ADDR_W-1:0]    ex_rd,
    input  logic [isa_pkg::REG_W-1:0]         ex_a,
    input  logic [isa_pkg::REG_W-1:0]         ex_b,
    input  logic [isa_pkg::IMM_W-1:0]         ex_imm,
    output logic [isa_pkg::REG_ADDR_W-1:0]    ex_busy_rd,
    output logic [isa_pkg::REG_ADDR_W-1:0]    mem_busy_rd,
    output logic                              ex_writes,
    output logic                              mem_writes,
    output logic [isa_pkg::REG_W-1:0]         alu_result,
    output logic [isa_pkg::MEM_ADDR_W-1:0]    mem_addr,
    output logic                              wb_en,
    output logic [isa_pkg::REG_ADDR_W-1:0]    wb_rd,
    output logic [isa_pkg::REG_W-1:0]         wb_data
);

    logic                           mem_valid;
    isa_pkg::opcode_e               mem_op;
    logic [isa_pkg::REG_ADDR_W-1:0] mem_rd;
    logic [isa_pkg::REG_W-1:0]      mem_result;
    logic [isa_pkg::REG_W-1:0]      dmem [isa_pkg::MEM_DEPTH];
    logic [isa_pkg::REG_W-1:0]      load_data;

    ////////////////////
    // execute
    ////////////////////

    always_comb begin
        case (ex_op)
            isa_pkg::LDI: alu_result = ex_imm;
            isa_pkg::ADD: alu_result = ex_a + ex_b;
            isa_pkg::SUB: alu_result = ex_a - ex_b;
            isa_pkg::AND: alu_result = ex_a & ex_b;
            // address base
            isa_pkg::LD:  alu_result = ex_a;
            // store data rides in the result slot
            isa_pkg::ST:  alu_result = ex_b;
            default:      alu_result = '0;
        endcase
    end

    // pending writer tags for the decode hazard check
    assign ex_busy_rd = ex_rd;
    assign ex_writes  = ex_valid && isa_pkg::writes_rd(ex_op);

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_op     <= ex_op;
        mem_rd     <= ex_rd;
        mem_result <= alu_result;
        mem_addr   <= ex_a[isa_pkg::MEM_ADDR_W-1:0];
    end

    ////////////////////
    // memory
    ////////////////////

    assign mem_busy_rd = mem_rd;
    assign mem_writes  = mem_valid && isa_pkg::writes_rd(mem_op);

    // 16 x 8 data memory, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < isa_pkg::MEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_valid && mem_op == isa_pkg::ST) begin
            dmem[mem_addr] <= mem_result;
        end
    end

    // a store one cycle earlier is already in the array
    assign load_data = dmem[mem_addr];

    ////////////////////
    // write-back
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= mem_valid && isa_pkg::writes_rd(mem_op);
        end
    end

    // ST leaves its stored value on wb_data
    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= (mem_op == isa_pkg::LD) ? load_data : mem_result;
    end

endmodule

// File: hw/fetch_decode.sv
// instruction latch, register file with write-first read, RAW hazard check and stall
`timescale 1ns/10ps

module fetch_decode (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              instr_valid,
    input  logic [isa_pkg::INSTR_W-1:0]       instr,
    input  logic                              wb_en,
    input  logic [isa_pkg::REG_ADDR_W-1:0]    wb_rd,
    input  logic [isa_pkg::REG_W-1:0]         wb_data,
    input  logic [isa_pkg::REG_ADDR_W-1:0]    ex_busy_rd,
    input  logic [isa_pkg::REG_ADDR_W-1:0]    mem_busy_rd,
    input  logic                              ex_writes,
    input  logic                              mem_writes,
    output logic                              stall,
    output logic                              ex_valid,
    output isa_pkg::opcode_e                  ex_op,
    output logic [isa_pkg::REG_ADDR_W-1:0]    ex_rd,
    output logic [isa_pkg::REG_W-1:0]         ex_a,
    output logic [isa_pkg::REG_W-1:0]         ex_b,
    output logic [isa_pkg::IMM_W-1:0]         ex_imm,
    output isa_pkg::opcode_e                  dec_op
);

    logic                           dec_valid;
    logic [isa_pkg::INSTR_W-1:0]    dec_instr;
    logic [isa_pkg::REG_W-1:0]      regs [isa_pkg::NUM_REGS];
    logic [isa_pkg::REG_ADDR_W-1:0] dec_rd;
    logic [isa_pkg::REG_ADDR_W-1:0] dec_rs1;
    logic [isa_pkg::REG_ADDR_W-1:0] dec_rs2;
    logic [isa_pkg::REG_ADDR_W-1:0] dec_rb;
    logic [isa_pkg::REG_W-1:0]      rd_a;
    logic [isa_pkg::REG_W-1:0]      rd_b;
    logic                           uses_a;
    logic                           uses_b;
    logic                           hit_a;
    logic                           hit_b;

    ////////////////////
    // fetch latch
    ////////////////////

    // held while stalled, source keeps instr stable too
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && instr_valid) begin
            dec_instr <= instr;
        end
    end

    ////////////////////
    // decode
    ////////////////////

    assign dec_op  = isa_pkg::opcode_e'(dec_instr[isa_pkg::OP_LSB +: isa_pkg::OPCODE_W]);
    assign dec_rd  = dec_instr[isa_pkg::RD_LSB +: isa_pkg::REG_ADDR_W];
    assign dec_rs1 = dec_instr[isa_pkg::RS1_LSB +: isa_pkg::REG_ADDR_W];
    assign dec_rs2 = dec_instr[isa_pkg::RS2_LSB +: isa_pkg::REG_ADDR_W];

    // ST sends its rd value down the b operand
    assign dec_rb = (dec_op == isa_pkg::ST) ? dec_rd : dec_rs2;

    // which read ports are live
    always_comb begin
        case (dec_op)
            isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND, isa_pkg::ST: begin
                uses_a = 1'b1;
                uses_b = 1'b1;
            end
            isa_pkg::LD: begin
                uses_a = 1'b1;
                uses_b = 1'b0;
            end
            default: begin
                uses_a = 1'b0;
                uses_b = 1'b0;
            end
        endcase
    end

    // register file, write at the edge
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-first read, so write-back needs no stall
    assign rd_a = (wb_en && wb_rd == dec_rs1) ? wb_data : regs[dec_rs1];
    assign rd_b = (wb_en && wb_rd == dec_rb) ? wb_data : regs[dec_rb];

    ////////////////////
    // hazard check
    ////////////////////

    // match against pending writers in execute and memory
    assign hit_a = (ex_writes && ex_busy_rd == dec_rs1) || (mem_writes && mem_busy_rd == dec_rs1);
    assign hit_b = (ex_writes && ex_busy_rd == dec_rb) || (mem_writes && mem_busy_rd == dec_rb);

    assign stall = dec_valid && ((uses_a && hit_a) || (uses_b && hit_b));

    ////////////////////
    // decode to execute
    ////////////////////

    // bubble into execute on stall
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid && !stall;
        end
    end

    always_ff @(posedge clk) begin
        ex_op  <= dec_op;
        ex_rd  <= dec_rd;
        ex_a   <= rd_a;
        ex_b   <= rd_b;
        ex_imm <= dec_instr[isa_pkg::IMM_LSB +: isa_pkg::IMM_W];
    end

endmodule

// File: hw/isa_pkg.sv
// ISA definitions with opcode enum, instruction field layout, register and memory sizes
package isa_pkg;

    ////////////////////
    // widths and sizes
    ////////////////////

    localparam int INSTR_W    = 16;
    localparam int OPCODE_W   = 4;
    localparam int REG_W      = 8;
    localparam int IMM_W      = 8;
    localparam int REG_ADDR_W = 2;
    localparam int NUM_REGS   = 4;
    localparam int MEM_ADDR_W = 4;
    localparam int MEM_DEPTH  = 1 << MEM_ADDR_W;

    // instruction field positions
    // imm sits under rs2 and the low bits
    localparam int OP_LSB  = 12;
    localparam int RD_LSB  = 10;
    localparam int RS1_LSB = 8;
    localparam int RS2_LSB = 6;
    localparam int IMM_LSB = 0;

    ////////////////////
    // opcodes
    ////////////////////

    typedef enum logic [OPCODE_W-1:0] {
        NOP = 4'h0,
        LDI = 4'h1,
        ADD = 4'h2,
        SUB = 4'h3,
        AND = 4'h4,
        LD  = 4'h5,
        ST  = 4'h6
    } opcode_e;

    // true for ops that update rd at write-back
    function automatic logic writes_rd(opcode_e op);
        return op inside {LDI, ADD, SUB, AND, LD};
    endfunction

endpackage

// File: hw/pipe_core.sv
// top level with fetch/decode, execute/memory and trace recorder
`timescale 1ns/10ps

module pipe_core (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 instr_valid,
    input  logic [isa_pkg::INSTR_W-1:0]          instr,
    output logic                                 hold,
    output logic                                 retire_valid,
    output logic [trace_pkg::SEQ_W-1:0]          retire_seq,
    output logic [trace_pkg::REC_INSTR_W-1:0]    retire_instr,
    output logic [trace_pkg::REC_RESULT_W-1:0]   retire_result,
    output logic [trace_pkg::REC_ADDR_W-1:0]     retire_addr
);

    // decode to execute
    logic                           ex_valid;
    isa_pkg::opcode_e               ex_op;
    logic [isa_pkg::REG_ADDR_W-1:0] ex_rd;
    logic [isa_pkg::REG_W-1:0]      ex_a;
    logic [isa_pkg::REG_W-1:0]      ex_b;
    logic [isa_pkg::IMM_W-1:0]      ex_imm;
    isa_pkg::opcode_e               dec_op;

    // write-back and hazard tags
    logic                           wb_en;
    logic [isa_pkg::REG_ADDR_W-1:0] wb_rd;
    logic [isa_pkg::REG_W-1:0]      wb_data;
    logic [isa_pkg::REG_ADDR_W-1:0] ex_busy_rd;
    logic [isa_pkg::REG_ADDR_W-1:0] mem_busy_rd;
    logic                           ex_writes;
    logic                           mem_writes;

    // stage data for the trace
    logic [isa_pkg::REG_W-1:0]      alu_result;
    logic [isa_pkg::MEM_ADDR_W-1:0] mem_addr;

    ////////////////////
    // stages
    ////////////////////

    // stall goes out as hold
    fetch_decode u_fetch_decode (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .ex_busy_rd  (ex_busy_rd),
        .mem_busy_rd (mem_busy_rd),
        .ex_writes   (ex_writes),
        .mem_writes  (mem_writes),
        .stall       (hold),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_rd       (ex_rd),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_imm      (ex_imm),
        .dec_op      (dec_op)
    );

    execute_memory u_execute_memory (
        .clk         (clk),
        .rst         (rst),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_rd       (ex_rd),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_imm      (ex_imm),
        .ex_busy_rd  (ex_busy_rd),
        .mem_busy_rd (mem_busy_rd),
        .ex_writes   (ex_writes),
        .mem_writes  (mem_writes),
        .alu_result  (alu_result),
        .mem_addr    (mem_addr),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    ////////////////////
    // trace
    ////////////////////

    trace_recorder u_trace_recorder (
        .clk           (clk),
        .rst           (rst),
        .stall         (hold),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .dec_op        (dec_op),
        .alu_result    (alu_result),
        .mem_addr      (mem_addr),
        .wb_data       (wb_data),
        .retire_valid  (retire_valid),
        .retire_seq    (retire_seq),
        .retire_instr  (retire_instr),
        .retire_result (retire_result),
        .retire_addr   (retire_addr)
    );

endmodule

// File: hw/trace_pkg.sv
// trace definitions with record depth, sequence and slot id widths, record field widths
package trace_pkg;

    ////////////////////
    // record table
    ////////////////////

    // sequence number given at fetch
    localparam int SEQ_W = 16;

    // slots in flight, more than the five stages
    localparam int TRACE_DEPTH = 8;
    localparam int ID_W        = 3;

    ////////////////////
    // record fields
    ////////////////////

    // raw instruction word
    localparam int REC_INSTR_W = isa_pkg::INSTR_W;

    // result byte seen at execute and write-back
    localparam int REC_RESULT_W = isa_pkg::REG_W;

    // data memory address of LD and ST
    localparam int REC_ADDR_W = isa_pkg::MEM_ADDR_W;

endpackage

// File: hw/trace_recorder.sv
// stall-aware id pipeline, per-stage record capture and retirement report
`timescale 1ns/10ps

module trace_recorder (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 stall,
    input  logic                                 instr_valid,
    input  logic [trace_pkg::REC_INSTR_W-1:0]    instr,
    input  isa_pkg::opcode_e                     dec_op,
    input  logic [trace_pkg::REC_RESULT_W-1:0]   alu_result,
    input  logic [trace_pkg::REC_ADDR_W-1:0]     mem_addr,
    input  logic [trace_pkg::REC_RESULT_W-1:0]   wb_data,
    output logic                                 retire_valid,
    output logic [trace_pkg::SEQ_W-1:0]          retire_seq,
    output logic [trace_pkg::REC_INSTR_W-1:0]    retire_instr,
    output logic [trace_pkg::REC_RESULT_W-1:0]   retire_result,
    output logic [trace_pkg::REC_ADDR_W-1:0]     retire_addr
);

    logic                              accept;
    logic [trace_pkg::SEQ_W-1:0]       seq_cnt;
    logic [trace_pkg::ID_W-1:0]        fetch_id;
    logic [trace_pkg::ID_W-1:0]        dec_id;
    logic [trace_pkg::ID_W-1:0]        ex_id;
    logic [trace_pkg::ID_W-1:0]        mem_id;
    logic [trace_pkg::ID_W-1:0]        wb_id;
    logic                              dec_v;
    logic                              ex_v;
    logic                              mem_v;
    logic                              wb_v;
    isa_pkg::opcode_e                  wb_op;

    // record table, one slot per id
    logic [trace_pkg::SEQ_W-1:0]        rec_seq    [trace_pkg::TRACE_DEPTH];
    logic [trace_pkg::REC_INSTR_W-1:0]  rec_instr  [trace_pkg::TRACE_DEPTH];
    isa_pkg::opcode_e                   rec_op     [trace_pkg::TRACE_DEPTH];
    logic [trace_pkg::REC_RESULT_W-1:0] rec_alu    [trace_pkg::TRACE_DEPTH];
    logic [trace_pkg::REC_ADDR_W-1:0]   rec_addr   [trace_pkg::TRACE_DEPTH];

    ////////////////////
    // id pipeline
    ////////////////////

    assign accept   = instr_valid && !stall;
    // slot index is the low bits of the sequence number
    assign fetch_id = seq_cnt[trace_pkg::ID_W-1:0];

    // mirrors the core, decode holds and execute takes a bubble on stall
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_cnt <= '0;
            dec_v   <= 1'b0;
            ex_v    <= 1'b0;
            mem_v   <= 1'b0;
            wb_v    <= 1'b0;
            dec_id  <= '0;
            ex_id   <= '0;
            mem_id  <= '0;
            wb_id   <= '0;
        end else begin
            if (accept) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
            if (!stall) begin
                dec_v  <= instr_valid;
                dec_id <= fetch_id;
                ex_v   <= dec_v;
                ex_id  <= dec_id;
            end else begin
                ex_v <= 1'b0;
            end
            mem_v  <= ex_v;
            mem_id <= ex_id;
            wb_v   <= mem_v;
            wb_id  <= mem_id;
        end
    end

    ////////////////////
    // stage capture
    ////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            rec_seq[fetch_id]   <= seq_cnt;
            rec_instr[fetch_id] <= instr;
        end
        // rewritten with the same op while stalled
        if (dec_v) begin
            rec_op[dec_id] <= dec_op;
        end
        if (ex_v) begin
            rec_alu[ex_id] <= alu_result;
        end
        if (mem_v) begin
            rec_addr[mem_id] <= mem_addr;
        end
    end

    ////////////////////
    // retirement
    ////////////////////

    // report lines up with the write-back stage of the core
    assign wb_op        = rec_op[wb_id];
    assign retire_valid = wb_v;
    assign retire_seq   = rec_seq[wb_id];
    assign retire_instr = rec_instr[wb_id];

    always_comb begin
        case (wb_op)
            isa_pkg::NOP: retire_result = '0;
            // stored value kept from execute
            isa_pkg::ST:  retire_result = rec_alu[wb_id];
            default:      retire_result = wb_data;
        endcase
        // address only reported for memory ops
        if (wb_op == isa_pkg::LD || wb_op == isa_pkg::ST) begin
            retire_addr = rec_addr[wb_id];
        end else begin
            retire_addr = '0;
        end
    end

endmodule

// File: pipe_core.f
hw/isa_pkg.sv
hw/trace_pkg.sv
hw/fetch_decode.sv
hw/execute_memory.sv
hw/trace_recorder.sv
hw/pipe_core.sv
verification/pipe_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the pipe_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f pipe_core.f --top-module pipe_core_tb -o pipe_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/pipe_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: verification/pipe_core_tb.sv
// testbench for pipe_core with golden-file stimulus, retirement checks, timeout and summary
`timescale 1ns/10ps

module pipe_core_tb;

    localparam int GOLD_WORDS = 64;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [15:0] instr;
    logic        hold;
    logic        retire_valid;
    logic [15:0] retire_seq;
    logic [15:0] retire_instr;
    logic [7:0]  retire_result;
    logic [3:0]  retire_addr;

    // word 0 count, then instruction entries, then expected records
    logic [47:0] gold [GOLD_WORDS];
    logic [47:0] exp_rec;
    int          n_instr;
    int          retired;
    int          errors;
    int          checks;
    int          err_mark;
    int          cycles;
    int          cycle_limit;
    int          quiet_retired;
    int          hold_cycles;
    int          exp_hold;

    pipe_core uut (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .hold          (hold),
        .retire_valid  (retire_valid),
        .retire_seq    (retire_seq),
        .retire_instr  (retire_instr),
        .retire_result (retire_result),
        .retire_addr   (retire_addr)
    );

    ////////////////////
    // clock and timeout
    ////////////////////

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run exceeded %0d cycles with %0d of %0d retired",
                     cycle_limit, retired, n_instr);
            $display("TEST FAIL");
            $finish;
        end
    end

    // one compare, mismatch reported on the spot
    task automatic compare_value(input string what, input logic [15:0] got,
                                 input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // hold cycles the hazard rule predicts for the golden stream
    // a source waits until its last writer has left memory
    function automatic int expected_hold_cycles();
        int          ready [4];
        int          prev_acc;
        int          acc;
        int          dec_end;
        int          total;
        logic [15:0] w;
        logic [3:0]  op;
        prev_acc = -1;
        dec_end  = -1;
        total    = 0;
        for (int r = 0; r < 4; r++) begin
            ready[r] = 0;
        end
        for (int i = 0; i < n_instr; i++) begin
            w  = gold[1 + i][15:0];
            op = w[15:12];
            // offered after its gap, taken once the previous one left decode
            acc = prev_acc + 1 + int'(gold[1 + i][31:16]);
            if (acc < dec_end + 1) begin
                acc = dec_end + 1;
            end
            dec_end = acc;
            // rs1 read by ADD, SUB, AND, LD and ST
            if (op inside {isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND, isa_pkg::LD, isa_pkg::ST}
                    && ready[w[9:8]] > dec_end) begin
                dec_end = ready[w[9:8]];
            end
            // rs2 read by the ALU ops
            if (op inside {isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND}
                    && ready[w[7:6]] > dec_end) begin
                dec_end = ready[w[7:6]];
            end
            // ST also reads rd
            if (op == isa_pkg::ST && ready[w[11:10]] > dec_end) begin
                dec_end = ready[w[11:10]];
            end
            total += dec_end - acc;
            // writer reaches write-back three cycles after leaving decode
            if (op inside {isa_pkg::LDI, isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND, isa_pkg::LD})
                    begin
                ready[w[11:10]] = dec_end + 3;
            end
            prev_acc = acc;
        end
        return total;
    endfunction

    ////////////////////
    // retirement check
    ////////////////////

    // outputs are registered, stable at the falling edge
    always @(negedge clk) begin
        // cycles spent stalled in decode
        if (!rst && hold) begin
            hold_cycles++;
        end
        if (!rst && retire_valid) begin
            if (retired >= n_instr) begin
                $display("unexpected retirement beyond the golden stream at %0t ns", $time);
                errors++;
            end else begin
                exp_rec  = gold[1 + n_instr + retired];
                err_mark = errors;
                compare_value("retire_seq", retire_seq, exp_rec[47:32]);
                compare_value("retire_instr", retire_instr, exp_rec[31:16]);
                compare_value("retire_result", {8'h00, retire_result}, {8'h00, exp_rec[15:8]});
                compare_value("retire_addr", {12'h000, retire_addr}, {12'h000, exp_rec[3:0]});
                if (errors == err_mark) begin
                    $display("retire %0d: ok", retired);
                end else begin
                    $display("retire %0d: mismatch", retired);
                end
            end
            retired++;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        rst           = 1'b1;
        instr_valid   = 1'b0;
        instr         = '0;
        retired       = 0;
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        hold_cycles   = 0;
        $readmemh("verification/pipe_golden.txt", gold);
        n_instr     = int'(gold[0][15:0]);
        cycle_limit = 4 * n_instr + 50;
        exp_hold    = expected_hold_cycles();

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle after reset, nothing may retire
        repeat (4) @(negedge clk);
        quiet_retired = retired;
        checks++;
        if (quiet_retired != 0) begin
            $display("retirement seen before any instruction was accepted");
            errors++;
        end
        $display("reset idle: %s", (quiet_retired == 0) ? "ok" : "bad");

        for (int i = 0; i < n_instr; i++) begin
            // idle gap cycles before this entry
            for (int g = 0; g < int'(gold[1 + i][31:16]); g++) begin
                instr_valid = 1'b0;
                @(negedge clk);
            end
            instr_valid = 1'b1;
            instr       = gold[1 + i][15:0];
            // keep it steady until a cycle without hold
            while (hold) @(negedge clk);
            @(negedge clk);
        end
        instr_valid = 1'b0;

        wait (retired >= n_instr);
        repeat (6) @(negedge clk);

        compare_value("hold cycles", 16'(hold_cycles), 16'(exp_hold));
        $display("hold cycles: %0d of %0d expected", hold_cycles, exp_hold);

        checks++;
        if (retired != n_instr) begin
            $display("retirement count %0d does not match %0d instructions", retired, n_instr);
            errors++;
        end
        $display("retire count: %0d of %0d", retired, n_instr);
        $display("summary: %0d checks, %0d errors, %0d retired", checks, errors, retired);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verification/pipe_golden.txt
// word 0: instruction count; next: {16'h0, gap cycles, instr}
// then expected records: {seq, instr, result, 4'h0, addr}
00000000000D
// independent LDI, ADD, SUB, AND
000000001005
000000001403
00000000180C
000000001C0A
000000002C40
000000003A40
000000004440
// dependent ADD, stalls on the AND
0000000021C0
// gap of 3, then ST and LD at address 9
000000036E00
000000005200
// gap of 2, NOP
000000020000
// ADD on the load result, SUB on the ADD
000000002400
0000000039C0
// expected retirement records
000010050500
000114030300
0002180C0C00
00031C0A0A00
00042C400800
00053A400900
000644400100
000721C00900
00086E000809
000952000809
000A00000000
000B24001000
000C39C00800
